/* hw/iob_pkg.sv */
package iob_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Bus geometry
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam int ADDR_W = 6;   // Sixteen word registers
   localparam int DATA_W = 32;

   // Word offsets of the board registers
   typedef enum logic [3:0] {
      REG_KBD_LO  = 4'd0,
      REG_KBD_HI  = 4'd1,
      REG_MOUSE_Y = 4'd2,
      REG_MOUSE_X = 4'd3,
      REG_BEEP    = 4'd4,
      REG_CSR     = 4'd5,
      REG_USEC_LO = 4'd8,
      REG_USEC_HI = 4'd9,
      REG_TICK    = 4'd10
   } iob_reg_e;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // CSR word, written and read differently
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Enable bits line up with the ready bits: 0 mouse, 1 keyboard, 2 tick
   typedef struct packed {
      logic [27:0] spare;   // Ignored on write
      logic        mode;
      logic [2:0]  irq_en;
   } iob_csr_ctrl_s;

   typedef struct packed {
      logic [24:0] zero;
      logic [2:0]  ready;   // Latched source flags
      logic        mode;
      logic [2:0]  irq_en;
   } iob_csr_stat_s;

   typedef union packed {
      logic [DATA_W-1:0] word;
      iob_csr_ctrl_s     ctrl;
      iob_csr_stat_s     stat;
   } iob_csr_u;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'd0,
      RESP_SLVERR = 2'd2
   } iob_resp_e;

endpackage

/* hw/iob_bus_if.sv */
`timescale 1ns/1ps

interface iob_bus_if;

   // Request, from decode
   logic                         req_valid;   // One-cycle pulse
   logic                         write;
   iob_pkg::iob_reg_e            sel;
   logic [iob_pkg::DATA_W-1:0]   wdata;
   logic                         hit;         // Aligned and mapped

   // Result, from execute
   logic [iob_pkg::DATA_W-1:0]   rdata;
   logic                         resp_valid;

   // Completion, from the response stage
   logic                         done;

   modport decode (
      output req_valid, write, sel, wdata, hit,
      input  done
   );

   modport execute (
      input  req_valid, write, sel, wdata, hit,
      output rdata, resp_valid
   );

   modport result (
      input  write, hit, rdata, resp_valid,
      output done
   );

endinterface

/* hw/iob_axi_decode.sv */
`timescale 1ns/1ps

module iob_axi_decode (
   input  logic                         clk,
   input  logic                         reset,

   input  logic [iob_pkg::ADDR_W-1:0]   awaddr,
   input  logic                         awvalid,
   output logic                         awready,

   input  logic [iob_pkg::DATA_W-1:0]   wdata,
   input  logic                         wvalid,
   output logic                         wready,

   input  logic [iob_pkg::ADDR_W-1:0]   araddr,
   input  logic                         arvalid,
   output logic                         arready,

   iob_bus_if.decode                    bus
);

   logic                         busy;       // One transaction in flight
   logic                         wr_accept;
   logic                         rd_accept;
   logic [iob_pkg::ADDR_W-1:0]   req_addr;
   logic [iob_pkg::ADDR_W-3:0]   word_off;
   logic                         map_hit;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Channel acceptance
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign wr_accept = !busy && awvalid && wvalid;                // Write wins a tie
   assign rd_accept = !busy && arvalid && !(awvalid && wvalid);

   assign awready = wr_accept;
   assign wready  = wr_accept;
   assign arready = rd_accept;

   assign req_addr = wr_accept ? awaddr : araddr;
   assign word_off = req_addr[iob_pkg::ADDR_W-1:2];

   // Only the offsets of the register map answer
   always_comb
   begin
      case (iob_pkg::iob_reg_e'(word_off))
         iob_pkg::REG_KBD_LO,
         iob_pkg::REG_KBD_HI,
         iob_pkg::REG_MOUSE_Y,
         iob_pkg::REG_MOUSE_X,
         iob_pkg::REG_BEEP,
         iob_pkg::REG_CSR,
         iob_pkg::REG_USEC_LO,
         iob_pkg::REG_USEC_HI,
         iob_pkg::REG_TICK:   map_hit = 1'b1;
         default:             map_hit = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy          <= 1'b0;
         bus.req_valid <= 1'b0;
      end
      else
      begin
         bus.req_valid <= wr_accept || rd_accept;
         if (wr_accept || rd_accept)
            busy <= 1'b1;
         else if (bus.done)
            busy <= 1'b0;                           // Response taken by the master
      end
   end

   // Request fields hold still until the next acceptance
   always_ff @(posedge clk)
   begin
      if (wr_accept || rd_accept)
      begin
         bus.write <= wr_accept;
         bus.sel   <= iob_pkg::iob_reg_e'(word_off);
         bus.hit   <= map_hit && (req_addr[1:0] == 2'b00);
         bus.wdata <= wdata;
      end
   end

endmodule

/* hw/iob_reg_execute.sv */
`timescale 1ns/1ps

module iob_reg_execute (
   input  logic          clk,
   input  logic          reset,

   iob_bus_if.execute    bus,

   input  logic          key_valid,
   input  logic [31:0]   key_code,

   input  logic          mouse_valid,
   input  logic [11:0]   mouse_x,
   input  logic [11:0]   mouse_y,
   input  logic [2:0]    mouse_buttons,
   input  logic [3:0]    mouse_raw,

   input  logic [31:0]   usec_count,
   input  logic [31:0]   tick_count,
   input  logic          tick_pulse,

   output logic          tick_start,
   output logic          beep,
   output logic          interrupt
);

   localparam int RDY_MOUSE = 0;
   localparam int RDY_KBD   = 1;
   localparam int RDY_TICK  = 2;

   logic [31:0]                  key_q;
   logic [11:0]                  mouse_x_q;
   logic [11:0]                  mouse_y_q;
   logic [2:0]                   buttons_q;
   logic [3:0]                   raw_q;
   logic [2:0]                   ready;
   logic [2:0]                   irq_en;
   logic                         mode;
   iob_pkg::iob_csr_u            csr_wr;
   iob_pkg::iob_csr_u            csr_rd;
   logic [iob_pkg::DATA_W-1:0]   read_word;
   logic                         rd_hit;
   logic                         wr_hit;

   assign rd_hit = bus.req_valid && bus.hit && !bus.write;
   assign wr_hit = bus.req_valid && bus.hit && bus.write;

   assign csr_wr    = iob_pkg::iob_csr_u'(bus.wdata);    // Control view
   assign interrupt = |(ready & irq_en);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Read mux
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb
   begin
      csr_rd             = '0;
      csr_rd.stat.ready  = ready;
      csr_rd.stat.mode   = mode;
      csr_rd.stat.irq_en = irq_en;

      case (bus.sel)
         iob_pkg::REG_KBD_LO:  read_word = {16'b0, key_q[15:0]};
         iob_pkg::REG_KBD_HI:  read_word = {16'b0, key_q[31:16]};
         iob_pkg::REG_MOUSE_Y: read_word = {17'b0, buttons_q, mouse_y_q};   // Head, middle, tail
         iob_pkg::REG_MOUSE_X: read_word = {16'b0, raw_q, mouse_x_q};
         iob_pkg::REG_CSR:     read_word = csr_rd.word;
         iob_pkg::REG_USEC_LO: read_word = {16'b0, usec_count[15:0]};
         iob_pkg::REG_USEC_HI: read_word = {16'b0, usec_count[31:16]};
         iob_pkg::REG_TICK:    read_word = tick_count;
         default:              read_word = '0;
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Registers and side effects
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         key_q          <= '0;
         mouse_x_q      <= '0;
         mouse_y_q      <= '0;
         buttons_q      <= '0;
         raw_q          <= '0;
         ready          <= '0;
         irq_en         <= '0;
         mode           <= 1'b0;
         beep           <= 1'b0;
         tick_start     <= 1'b0;
         bus.resp_valid <= 1'b0;
      end
      else
      begin
         bus.resp_valid <= bus.req_valid;     // Misses are answered too
         tick_start     <= rd_hit && (bus.sel == iob_pkg::REG_TICK);

         if (rd_hit)
         begin
            case (bus.sel)
               iob_pkg::REG_KBD_LO,
               iob_pkg::REG_KBD_HI:  ready[RDY_KBD]   <= 1'b0;
               iob_pkg::REG_MOUSE_Y: ready[RDY_MOUSE] <= 1'b0;
               iob_pkg::REG_TICK:    ready[RDY_TICK]  <= 1'b0;
               default:              ;
            endcase
         end

         if (wr_hit && bus.sel == iob_pkg::REG_CSR)
         begin
            irq_en <= csr_wr.ctrl.irq_en;
            mode   <= csr_wr.ctrl.mode;
         end
         if (wr_hit && bus.sel == iob_pkg::REG_BEEP)
            beep <= !beep;

         // New data sets its flag even when a read clears it in the same cycle
         if (key_valid)
         begin
            key_q          <= key_code;
            ready[RDY_KBD] <= 1'b1;
         end
         if (mouse_valid)
         begin
            mouse_x_q        <= mouse_x;
            mouse_y_q        <= mouse_y;
            buttons_q        <= mouse_buttons;
            raw_q            <= mouse_raw;
            ready[RDY_MOUSE] <= 1'b1;
         end
         if (tick_pulse)
            ready[RDY_TICK] <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (bus.req_valid)
         bus.rdata <= rd_hit ? read_word : '0;
   end

endmodule

/* hw/iob_timers.sv */
`timescale 1ns/1ps

module iob_timers #(
   parameter int CLK_HZ  = 50_000_000,
   parameter int TICK_HZ = 60
) (
   input  logic          clk,
   input  logic          reset,
   input  logic          tick_start,
   output logic [31:0]   usec_count,
   output logic [31:0]   tick_count,
   output logic          tick_pulse
);

   localparam int USEC_DIV = CLK_HZ / 1_000_000;
   localparam int TICK_DIV = CLK_HZ / TICK_HZ;
   localparam int USEC_PW  = $clog2(USEC_DIV + 1);
   localparam int TICK_PW  = $clog2(TICK_DIV + 1);

   logic [USEC_PW-1:0]   usec_pre;
   logic [TICK_PW-1:0]   tick_pre;
   logic                 tick_en;     // Sticky once started
   logic                 usec_wrap;
   logic                 tick_wrap;

   assign usec_wrap = usec_pre == USEC_PW'(USEC_DIV - 1);
   assign tick_wrap = tick_pre == TICK_PW'(TICK_DIV - 1);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Free-running microsecond clock
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         usec_pre   <= '0;
         usec_count <= '0;
      end
      else if (usec_wrap)
      begin
         usec_pre   <= '0;
         usec_count <= usec_count + 32'd1;
      end
      else
         usec_pre <= usec_pre + 1'b1;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Tick clock, idle until first started
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tick_en    <= 1'b0;
         tick_pre   <= '0;
         tick_count <= '0;
         tick_pulse <= 1'b0;
      end
      else
      begin
         if (tick_start)
            tick_en <= 1'b1;
         tick_pulse <= tick_en && tick_wrap;
         if (tick_en)
         begin
            if (tick_wrap)
            begin
               tick_pre   <= '0;
               tick_count <= tick_count + 32'd1;
            end
            else
               tick_pre <= tick_pre + 1'b1;
         end
      end
   end

endmodule

/* hw/iob_axi_result.sv */
`timescale 1ns/1ps

module iob_axi_result (
   input  logic                         clk,
   input  logic                         reset,

   iob_bus_if.result                    bus,

   output logic [1:0]                   bresp,
   output logic                         bvalid,
   input  logic                         bready,

   output logic [iob_pkg::DATA_W-1:0]   rdata,
   output logic [1:0]                   rresp,
   output logic                         rvalid,
   input  logic                         rready
);

   iob_pkg::iob_resp_e   resp_code;
   logic                 b_take;
   logic                 r_take;

   assign resp_code = bus.hit ? iob_pkg::RESP_OKAY : iob_pkg::RESP_SLVERR;
   assign b_take    = bvalid && bready;
   assign r_take    = rvalid && rready;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Response valids and completion
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         bvalid   <= 1'b0;
         rvalid   <= 1'b0;
         bus.done <= 1'b0;
      end
      else
      begin
         bus.done <= b_take || r_take;     // Frees decode for the next request

         if (bus.resp_valid && bus.write)
            bvalid <= 1'b1;
         else if (b_take)
            bvalid <= 1'b0;

         if (bus.resp_valid && !bus.write)
            rvalid <= 1'b1;
         else if (r_take)
            rvalid <= 1'b0;
      end
   end

   // Payload is loaded once and held under back-pressure
   always_ff @(posedge clk)
   begin
      if (bus.resp_valid)
      begin
         if (bus.write)
            bresp <= resp_code;
         else
         begin
            rresp <= resp_code;
            rdata <= bus.rdata;
         end
      end
   end

endmodule

/* hw/iob_top.sv */
`timescale 1ns/1ps

module iob_top #(
   parameter int CLK_HZ  = 50_000_000,
   parameter int TICK_HZ = 60
) (
   input  logic                         clk,
   input  logic                         reset,

   // AXI4-Lite slave
   input  logic [iob_pkg::ADDR_W-1:0]   awaddr,
   input  logic                         awvalid,
   output logic                         awready,
   input  logic [iob_pkg::DATA_W-1:0]   wdata,
   input  logic [3:0]                   wstrb,      // Unused, registers are word-wide
   input  logic                         wvalid,
   output logic                         wready,
   output logic [1:0]                   bresp,
   output logic                         bvalid,
   input  logic                         bready,
   input  logic [iob_pkg::ADDR_W-1:0]   araddr,
   input  logic                         arvalid,
   output logic                         arready,
   output logic [iob_pkg::DATA_W-1:0]   rdata,
   output logic [1:0]                   rresp,
   output logic                         rvalid,
   input  logic                         rready,

   // Keyboard and mouse
   input  logic                         key_valid,
   input  logic [31:0]                  key_code,
   input  logic                         mouse_valid,
   input  logic [11:0]                  mouse_x,
   input  logic [11:0]                  mouse_y,
   input  logic [2:0]                   mouse_buttons,
   input  logic [3:0]                   mouse_raw,

   output logic                         beep,
   output logic                         interrupt
);

   logic [31:0]   usec_count;
   logic [31:0]   tick_count;
   logic          tick_pulse;
   logic          tick_start;

   iob_bus_if bus ();

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Decode, execute, result
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   iob_axi_decode u_decode (
      .clk     (clk),
      .reset   (reset),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wvalid  (wvalid),
      .wready  (wready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .bus     (bus.decode)
   );

   iob_reg_execute u_execute (
      .clk           (clk),
      .reset         (reset),
      .bus           (bus.execute),
      .key_valid     (key_valid),
      .key_code      (key_code),
      .mouse_valid   (mouse_valid),
      .mouse_x       (mouse_x),
      .mouse_y       (mouse_y),
      .mouse_buttons (mouse_buttons),
      .mouse_raw     (mouse_raw),
      .usec_count    (usec_count),
      .tick_count    (tick_count),
      .tick_pulse    (tick_pulse),
      .tick_start    (tick_start),
      .beep          (beep),
      .interrupt     (interrupt)
   );

   iob_timers #(
      .CLK_HZ  (CLK_HZ),
      .TICK_HZ (TICK_HZ)
   ) u_timers (
      .clk        (clk),
      .reset      (reset),
      .tick_start (tick_start),
      .usec_count (usec_count),
      .tick_count (tick_count),
      .tick_pulse (tick_pulse)
   );

   iob_axi_result u_result (
      .clk    (clk),
      .reset  (reset),
      .bus    (bus.result),
      .bresp  (bresp),
      .bvalid (bvalid),
      .bready (bready),
      .rdata  (rdata),
      .rresp  (rresp),
      .rvalid (rvalid),
      .rready (rready)
   );

endmodule

/* tests/tb_iob_tasks.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expected values and compares
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// CSR status view: ready flags over mode over enables
function automatic logic [31:0] csr_status(input logic [2:0] ready, input logic mode,
                                           input logic [2:0] en);
   csr_status = {25'b0, ready, mode, en};
endfunction

task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
   if (act !== exp)
   begin
      errors++;
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
   end
endtask

task automatic check_range(input string name, input logic [31:0] lo, input logic [31:0] hi,
                           input logic [31:0] act);
   if (act < lo || act > hi)
   begin
      errors++;
      $display("Fail at %0t ns: %s expected %0d to %0d got %0d", $time, name, lo, hi, act);
   end
endtask

task automatic check_resp(input string name, input iob_pkg::iob_resp_e exp,
                          input iob_pkg::iob_resp_e act);
   if (act !== exp)
   begin
      errors++;
      $display("Fail at %0t ns: %s expected %s got %s", $time, name, exp.name(), act.name());
   end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
   if (act !== exp)
   begin
      errors++;
      $display("Fail at %0t ns: %s expected %b got %b", $time, name, exp, act);
   end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Drivers, entered and left 1 ns after a rising edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic wait_cycles(input int n);
   repeat (n) @(posedge clk);
   #1;
endtask

task automatic pulse_key(input logic [31:0] code);
   key_code  = code;
   key_valid = 1'b1;
   wait_cycles(1);
   key_valid = 1'b0;
endtask

task automatic pulse_mouse(input logic [31:0] rnd);
   mouse_x       = rnd[11:0];
   mouse_y       = rnd[23:12];
   mouse_buttons = rnd[26:24];
   mouse_raw     = rnd[30:27];
   mouse_valid   = 1'b1;
   wait_cycles(1);
   mouse_valid   = 1'b0;
endtask

// Response must come 2 cycles after the handshake
task automatic axi_write(input logic [5:0] addr, input logic [31:0] data,
                         output iob_pkg::iob_resp_e resp);
   int lat;
   awaddr  = addr;
   wdata   = data;
   awvalid = 1'b1;
   wvalid  = 1'b1;
   #1;
   while (!awready)
   begin
      @(posedge clk);
      #2;
   end
   check_bit("wready", 1'b1, wready);   // Data channel taken with the address
   wait_cycles(1);                 // Handshake edge
   awvalid = 1'b0;
   wvalid  = 1'b0;
   lat     = 0;
   while (!bvalid && lat < 8)
   begin
      wait_cycles(1);
      lat++;
   end
   check_data("bvalid latency", 32'd2, lat);
   resp = iob_pkg::iob_resp_e'(bresp);
   wait_cycles(1);                 // B transfer, bready high
endtask

task automatic axi_read(input logic [5:0] addr, output logic [31:0] data,
                        output iob_pkg::iob_resp_e resp);
   int lat;
   araddr  = addr;
   arvalid = 1'b1;
   #1;
   while (!arready)
   begin
      @(posedge clk);
      #2;
   end
   wait_cycles(1);
   arvalid = 1'b0;
   lat     = 0;
   while (!rvalid && lat < 8)
   begin
      wait_cycles(1);
      lat++;
   end
   check_data("rvalid latency", 32'd2, lat);
   data = rdata;
   resp = iob_pkg::iob_resp_e'(rresp);
   wait_cycles(1);
endtask

task automatic read_and_compare(input logic [5:0] addr, input logic [31:0] exp,
                                input iob_pkg::iob_resp_e exp_resp);
   logic [31:0]          data;
   iob_pkg::iob_resp_e   resp;
   axi_read(addr, data, resp);
   check_data("rdata", exp, data);
   check_resp("rresp", exp_resp, resp);
endtask

task automatic write_and_compare(input logic [5:0] addr, input logic [31:0] data,
                                 input iob_pkg::iob_resp_e exp_resp);
   iob_pkg::iob_resp_e   resp;
   axi_write(addr, data, resp);
   check_resp("bresp", exp_resp, resp);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic csr_and_beep();
   read_and_compare(ADDR_CSR, 32'd0, iob_pkg::RESP_OKAY);
   write_and_compare(ADDR_CSR, 32'hFFFF_FFF7, iob_pkg::RESP_OKAY);   // Upper bits ignored
   read_and_compare(ADDR_CSR, csr_status(3'b000, 1'b0, 3'b111), iob_pkg::RESP_OKAY);
   check_bit("beep", 1'b0, beep);
   write_and_compare(ADDR_BEEP, 32'd0, iob_pkg::RESP_OKAY);
   check_bit("beep", 1'b1, beep);
   write_and_compare(ADDR_BEEP, 32'hFFFF_FFFF, iob_pkg::RESP_OKAY);
   check_bit("beep", 1'b0, beep);
endtask

task automatic keyboard_path();
   key_word = $random(seed);
   pulse_key(key_word);
   read_and_compare(ADDR_CSR, csr_status(3'b010, 1'b0, 3'b111), iob_pkg::RESP_OKAY);
   check_bit("interrupt", 1'b1, interrupt);
   read_and_compare(ADDR_KBD_LO, {16'b0, key_word[15:0]}, iob_pkg::RESP_OKAY);
   read_and_compare(ADDR_KBD_HI, {16'b0, key_word[31:16]}, iob_pkg::RESP_OKAY);
   read_and_compare(ADDR_CSR, csr_status(3'b000, 1'b0, 3'b111), iob_pkg::RESP_OKAY);
   check_bit("interrupt", 1'b0, interrupt);
endtask

task automatic mouse_path();
   logic [31:0] rnd;
   rnd = $random(seed);
   pulse_mouse(rnd);
   mouse_x_word = {16'b0, rnd[30:27], rnd[11:0]};
   read_and_compare(ADDR_CSR, csr_status(3'b001, 1'b0, 3'b111), iob_pkg::RESP_OKAY);
   check_bit("interrupt", 1'b1, interrupt);
   read_and_compare(ADDR_MOUSE_Y, {17'b0, rnd[26:24], rnd[23:12]}, iob_pkg::RESP_OKAY);
   read_and_compare(ADDR_CSR, csr_status(3'b000, 1'b0, 3'b111), iob_pkg::RESP_OKAY);
   read_and_compare(ADDR_MOUSE_X, mouse_x_word, iob_pkg::RESP_OKAY);
endtask

task automatic error_responses();
   read_and_compare(ADDR_UNMAPPED, 32'd0, iob_pkg::RESP_SLVERR);
   write_and_compare(ADDR_UNMAPPED, 32'hFFFF_FFFF, iob_pkg::RESP_SLVERR);
   read_and_compare(ADDR_UNALIGNED, 32'd0, iob_pkg::RESP_SLVERR);
   write_and_compare(ADDR_UNALIGNED, 32'd0, iob_pkg::RESP_SLVERR);      // Would clear enables
   write_and_compare(ADDR_BEEP + 6'd1, 32'd0, iob_pkg::RESP_SLVERR);    // Would toggle beep
   read_and_compare(ADDR_CSR, csr_status(3'b000, 1'b0, 3'b111), iob_pkg::RESP_OKAY);
   check_bit("beep", 1'b0, beep);
endtask

task automatic timer_counts();
   logic [31:0]          first;
   logic [31:0]          second;
   iob_pkg::iob_resp_e   resp;
   int                   t0;
   int                   n;
   wait_cycles(3);                 // Decode idle so both reads start alike
   t0 = cycles;
   axi_read(ADDR_USEC_LO, first, resp);
   wait_cycles(37);
   n = cycles - t0;
   axi_read(ADDR_USEC_LO, second, resp);
   check_range("usec delta", n / 4 - 1, (n + 3) / 4 + 1, (second - first) & 32'h0000_FFFF);

   read_and_compare(ADDR_TICK, 32'd0, iob_pkg::RESP_OKAY);            // Starts the tick clock
   wait_cycles(100);
   check_bit("interrupt", 1'b1, interrupt);
   read_and_compare(ADDR_CSR, csr_status(3'b100, 1'b0, 3'b111), iob_pkg::RESP_OKAY);
   axi_read(ADDR_TICK, second, resp);
   check_range("tick count", 32'd2, 32'hFFFF_FFFF, second);
   check_resp("rresp", iob_pkg::RESP_OKAY, resp);
endtask

task automatic read_back_pressure();
   logic [31:0]   held;
   int            lat;
   rready  = 1'b0;
   araddr  = ADDR_MOUSE_X;
   arvalid = 1'b1;
   #1;
   while (!arready)
   begin
      @(posedge clk);
      #2;
   end
   wait_cycles(1);
   lat = 0;                        // arvalid stays high for a second read
   while (!rvalid && lat < 8)
   begin
      wait_cycles(1);
      lat++;
   end
   check_data("rvalid latency", 32'd2, lat);
   held = rdata;
   check_data("rdata", mouse_x_word, held);
   repeat (10)
   begin
      wait_cycles(1);
      check_bit("rvalid", 1'b1, rvalid);
      check_data("rdata", held, rdata);
      check_bit("arready", 1'b0, arready);
   end
   rready = 1'b1;
   read_and_compare(ADDR_MOUSE_X, mouse_x_word, iob_pkg::RESP_OKAY);
endtask

/* tests/tb_iob_top.sv */
`timescale 1ns/1ps

module tb_iob_top;

   localparam int CLK_HZ     = 4_000_000;    // Microsecond divisor of 4
   localparam int TICK_HZ    = 100_000;      // Tick divisor of 40
   localparam int MAX_CYCLES = 2000;

   // Byte addresses of the register map
   localparam logic [5:0] ADDR_KBD_LO    = 6'h00;
   localparam logic [5:0] ADDR_KBD_HI    = 6'h04;
   localparam logic [5:0] ADDR_MOUSE_Y   = 6'h08;
   localparam logic [5:0] ADDR_MOUSE_X   = 6'h0C;
   localparam logic [5:0] ADDR_BEEP      = 6'h10;
   localparam logic [5:0] ADDR_CSR       = 6'h14;
   localparam logic [5:0] ADDR_USEC_LO   = 6'h20;
   localparam logic [5:0] ADDR_TICK      = 6'h28;
   localparam logic [5:0] ADDR_UNMAPPED  = 6'h30;   // Word offset 12
   localparam logic [5:0] ADDR_UNALIGNED = 6'h15;   // One byte into the CSR

   logic          clk;
   logic          reset;
   logic [5:0]    awaddr;
   logic          awvalid;
   logic          awready;
   logic [31:0]   wdata;
   logic [3:0]    wstrb;
   logic          wvalid;
   logic          wready;
   logic [1:0]    bresp;
   logic          bvalid;
   logic          bready;
   logic [5:0]    araddr;
   logic          arvalid;
   logic          arready;
   logic [31:0]   rdata;
   logic [1:0]    rresp;
   logic          rvalid;
   logic          rready;
   logic          key_valid;
   logic [31:0]   key_code;
   logic          mouse_valid;
   logic [11:0]   mouse_x;
   logic [11:0]   mouse_y;
   logic [2:0]    mouse_buttons;
   logic [3:0]    mouse_raw;
   logic          beep;
   logic          interrupt;

   integer        seed;
   int            errors;
   int            cycles;
   logic [31:0]   key_word;        // Last keyboard code sent
   logic [31:0]   mouse_x_word;    // Expected Mouse X read, raw over x

   iob_top #(
      .CLK_HZ  (CLK_HZ),
      .TICK_HZ (TICK_HZ)
   ) u_iob_top (
      .clk           (clk),
      .reset         (reset),
      .awaddr        (awaddr),
      .awvalid       (awvalid),
      .awready       (awready),
      .wdata         (wdata),
      .wstrb         (wstrb),
      .wvalid        (wvalid),
      .wready        (wready),
      .bresp         (bresp),
      .bvalid        (bvalid),
      .bready        (bready),
      .araddr        (araddr),
      .arvalid       (arvalid),
      .arready       (arready),
      .rdata         (rdata),
      .rresp         (rresp),
      .rvalid        (rvalid),
      .rready        (rready),
      .key_valid     (key_valid),
      .key_code      (key_code),
      .mouse_valid   (mouse_valid),
      .mouse_x       (mouse_x),
      .mouse_y       (mouse_y),
      .mouse_buttons (mouse_buttons),
      .mouse_raw     (mouse_raw),
      .beep          (beep),
      .interrupt     (interrupt)
   );

   `include "tb_iob_tasks.svh"

   always #10 clk = ~clk;          // 20 ns period

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Run limit
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
         $display("=== FAIL ===");
         $finish;
      end
   end

   initial
   begin
      clk           = 1'b0;
      reset         = 1'b1;
      awaddr        = '0;
      awvalid       = 1'b0;
      wdata         = '0;
      wstrb         = 4'hF;
      wvalid        = 1'b0;
      bready        = 1'b1;
      araddr        = '0;
      arvalid       = 1'b0;
      rready        = 1'b1;
      key_valid     = 1'b0;
      key_code      = '0;
      mouse_valid   = 1'b0;
      mouse_x       = '0;
      mouse_y       = '0;
      mouse_buttons = '0;
      mouse_raw     = '0;
      seed          = 54;
      errors        = 0;
      cycles        = 0;
      key_word      = '0;
      mouse_x_word  = '0;

      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;

      csr_and_beep();
      keyboard_path();
      mouse_path();
      error_responses();
      timer_counts();
      read_back_pressure();

      $display("Checks failed: %0d", errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

/* project.f */
+incdir+tests
hw/iob_pkg.sv
hw/iob_bus_if.sv
hw/iob_axi_decode.sv
hw/iob_reg_execute.sv
hw/iob_timers.sv
hw/iob_axi_result.sv
hw/iob_top.sv
tests/tb_iob_top.sv

/* Bender.yml */
package:
  name: iob_board

sources:
  # Design, in compile order
  - files:
      - hw/iob_pkg.sv
      - hw/iob_bus_if.sv
      - hw/iob_axi_decode.sv
      - hw/iob_reg_execute.sv
      - hw/iob_timers.sv
      - hw/iob_axi_result.sv
      - hw/iob_top.sv

  # Testbench, pulls in tests/tb_iob_tasks.svh
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_iob_top.sv
